/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - include
    files:
      - hdl/fetch_pkg.sv
      - hdl/predecoder.sv
      - hdl/branch_predictor.sv
      - hdl/fetch_ctrl.sv
      - hdl/fetch_pc_gen.sv
      - hdl/inst_fifo.sv
      - hdl/fetch_frontend.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/fetch_frontend_assertions.sv
      - dv/fetch_frontend_tb.sv

/* dv/fetch_frontend_assertions.sv */
`timescale 1ns/1ps
`include "la_opcodes.svh"

module fetch_frontend_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input fetch_pkg::icache_rsp_t icache_rsp,
    input fetch_pkg::addr_t      fetch_pc,
    input logic                  hint,
    input fetch_pkg::slot_mask_t slot_valid,
    input fetch_pkg::bpu_read_t  bpu_rd,
    input fetch_pkg::fifo_cnt_t  fifo_count,
    input logic                  refill_req,
    input fetch_pkg::addr_t      refill_pc,
    input logic                  refill_done,
    input logic                  pop,
    input logic                  head_valid
);
    import fetch_pkg::*;

    int unsigned err_cnt = 0;
    slot_mask_t  exp_mask;
    logic        exp_miss;
    addr_t       exp_miss_pc;
    addr_t       exp_next;
    logic        held;
    logic        refilling;
    fifo_cnt_t   q_cnt;

    // expected group from the opcode and predictor view of each slot
    always_comb begin
        logic               live;
        addr_t              pc_i;
        logic signed [25:0] off26;
        live        = hint;
        exp_mask    = '0;
        exp_miss    = 1'b0;
        exp_miss_pc = '0;
        exp_next    = fetch_pc + 32'd16;
        off26       = '0;
        for (int i = 0; i < fetch_width; i++) begin
            pc_i = fetch_pc + 32'(4 * i);
            if (live && !icache_rsp.found[i]) begin
                exp_miss    = 1'b1;
                exp_miss_pc = pc_i;
                live        = 1'b0;
            end else if (live) begin
                exp_mask[i] = 1'b1;
                casez (icache_rsp.inst[i])
                    `B, `BL: begin
                        // word offset, upper ten bits sit low in the word
                        off26    = {icache_rsp.inst[i][9:0], icache_rsp.inst[i][25:10]};
                        exp_next = pc_i + (32'(off26) << 2);
                        live     = 1'b0;
                    end
                    default: begin
                        if (bpu_rd.hit[i] && bpu_rd.predict[i]) begin
                            exp_next = bpu_rd.target[i];
                            live     = 1'b0;
                        end
                    end
                endcase
            end
        end
        if (exp_miss) begin
            exp_next = exp_miss_pc;
        end
        if (!hint) begin
            exp_next = fetch_pc;
        end
    end

    // refill lasts from the request up to the done edge
    assign refilling = refill_req | held;
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else begin
            held <= refilling & ~refill_done;
        end
    end

    // queue occupancy from the expected pushes and the pops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_cnt <= '0;
        end else begin
            q_cnt <= q_cnt + fifo_cnt_t'($countones(exp_mask))
                     - fifo_cnt_t'(pop && q_cnt != '0);
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |=> fetch_pc == '0 && !refill_req && !head_valid)
        else begin err_cnt++; $error("state after reset is not clean"); end
    a_mask: assert property (@(posedge clk) disable iff (!rst_n) slot_valid == exp_mask)
        else begin
            err_cnt++;
            $error("Fail slot_valid exp %h got %h", $sampled(exp_mask), $sampled(slot_valid));
        end
    a_next: assert property (@(posedge clk) disable iff (!rst_n) 1'b1 |=> fetch_pc == $past(exp_next))
        else begin
            err_cnt++;
            $error("Fail fetch_pc exp %h got %h", $past(exp_next), $sampled(fetch_pc));
        end
    a_refill: assert property (@(posedge clk) disable iff (!rst_n)
                              hint && exp_miss |=> refill_req && refill_pc == $past(exp_miss_pc))
        else begin
            err_cnt++;
            $error("Fail refill_pc exp %h got %h", $past(exp_miss_pc), $sampled(refill_pc));
        end
    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) refill_req |=> !refill_req)
        else begin err_cnt++; $error("refill request lasted more than one cycle"); end
    a_wait: assert property (@(posedge clk) disable iff (!rst_n) refilling |-> !hint)
        else begin err_cnt++; $error("fetch ran during a refill"); end
    a_room: assert property (@(posedge clk) disable iff (!rst_n)
                            !refilling |-> hint == (q_cnt <= 5'd12))
        else begin err_cnt++; $error("fetch gate did not follow the room in the queue"); end
    a_count: assert property (@(posedge clk) disable iff (!rst_n) fifo_count == q_cnt)
        else begin
            err_cnt++;
            $error("Fail fifo_count exp %h got %h", $sampled(q_cnt), $sampled(fifo_count));
        end

endmodule

bind fetch_frontend fetch_frontend_assertions u_checks (
    .clk(clk), .rst_n(rst_n), .icache_rsp(icache_rsp), .fetch_pc(fetch_pc), .hint(hint),
    .slot_valid(slot_valid), .bpu_rd(bpu_rd), .fifo_count(fifo_count), .refill_req(refill_req),
    .refill_pc(refill_pc), .refill_done(refill_done), .pop(pop), .head_valid(head_valid)
);

/* dv/fetch_frontend_tb.sv */
`timescale 1ns/1ps

module fetch_frontend_tb;
    import fetch_pkg::*;

    // test lengths plus one reset of three cycles per test
    localparam int run_cycles_total = 40 + 30 + 82 + 80 + 40 + 8 + 6 * 3 + 1;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    icache_rsp_t icache_rsp;
    addr_t fetch_pc;
    addr_t refill_pc;
    logic refill_req;
    logic refill_done = 1'b0;
    logic pop = 1'b1;
    logic head_valid;
    bpu_resolve_t resolve = '0;
    fetch_entry_t head;

    inst_t prog [256];
    logic [63:0] absent = '0;
    logic [7:0] lfsr = 8'd36;
    logic check_order = 1'b0;
    addr_t expect_pc;
    int tb_err = 0;
    int err_mark = 0;
    int n_pass = 0;
    int n_fail = 0;

    fetch_frontend UUT (.*);

    always #5 clk = ~clk;

    // cache answers in the same cycle
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            icache_rsp.inst[i]  = prog[8'((fetch_pc + 32'(4 * i)) >> 2)];
            icache_rsp.found[i] = !absent[6'((fetch_pc + 32'(4 * i)) >> 4)];
        end
    end

    function automatic logic lfsr_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    function automatic inst_t jump_word(logic [5:0] opc, addr_t from, addr_t to);
        logic [25:0] off;
        off = 26'((to - from) >> 2);
        return {opc, off[15:0], off[25:16]};
    endfunction

    function automatic inst_t branch_word(logic [5:0] opc, addr_t from, addr_t to);
        logic [15:0] off;
        off = 16'((to - from) >> 2);
        return {opc, off, 10'd0};
    endfunction

    // refill model with a pseudo random latency
    always begin
        int wait_n;
        @(posedge clk);
        if (rst_n && refill_req) begin
            wait_n = {lfsr_bit(), lfsr_bit(), lfsr_bit()} + 1;
            repeat (wait_n) @(posedge clk);
            #1 refill_done = 1'b1;
            absent[refill_pc[9:4]] = 1'b0;
            @(posedge clk);
            #1 refill_done = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && pop && head_valid) begin
            if (head.inst !== prog[head.pc[9:2]]) begin
                tb_err++;
                $display("Fail head.inst exp %h got %h", prog[head.pc[9:2]], head.inst);
            end
            if (check_order && head.pc !== expect_pc) begin
                tb_err++;
                $display("Fail head.pc exp %h got %h", expect_pc, head.pc);
            end
            expect_pc <= head.pc + 32'd4;
        end
    end

    task automatic reset_dut();
        rst_n = 1'b0;
        pop = 1'b1;
        absent = '0;
        expect_pc = '0;
        for (int a = 0; a < 256; a++) begin
            prog[a] = {6'b000010, 16'(a), 10'(a * 3)};
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic step(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_pc(addr_t pc, int limit);
        int n = 0;
        while (fetch_pc !== pc && n < limit) begin
            step(1);
            n++;
        end
        if (fetch_pc !== pc) begin
            tb_err++;
            $display("fetch never reached the trained branch target");
        end
    endtask

    task automatic end_test(string name);
        int errs;
        errs = tb_err + int'(UUT.u_checks.err_cnt) - err_mark;
        err_mark = tb_err + int'(UUT.u_checks.err_cnt);
        if (errs == 0) n_pass++;
        else n_fail++;
        $display("%s: %0d errors", name, errs);
    endtask

    initial begin
        #(run_cycles_total * 10 + 2000);
        $display("watchdog expired, run did not finish");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        @(posedge clk);
        #1 reset_dut();
        check_order = 1'b1;
        step(40);
        check_order = 1'b0;
        end_test("sequential fetch");

        reset_dut();
        prog[8'h18 >> 2] = jump_word(6'b010100, 32'h18, 32'h100);
        prog[32'h104 >> 2] = jump_word(6'b010101, 32'h104, 32'h10);
        step(30);
        end_test("unconditional jump");

        reset_dut();
        prog[8'h48 >> 2] = branch_word(6'b010110, 32'h48, 32'h80);
        prog[8'h70 >> 2] = jump_word(6'b010100, 32'h70, 32'h0);
        prog[8'h80 >> 2] = jump_word(6'b010100, 32'h80, 32'h0);
        step(20);
        resolve = '{valid: 1'b1, pc: 32'h48, taken: 1'b1};
        step(2);
        resolve = '0;
        wait_pc(32'h80, 60);
        end_test("trained branch");

        reset_dut();
        prog[0] = jump_word(6'b010100, 32'h0, 32'h14);
        prog[8'h60 >> 2] = jump_word(6'b010100, 32'h60, 32'h0);
        absent[2] = 1'b1;
        absent[5] = 1'b1;
        step(80);
        end_test("cache miss");

        reset_dut();
        pop = 1'b0;
        step(20);
        pop = 1'b1;
        step(20);
        end_test("back-pressure");

        step(5);
        reset_dut();
        step(3);
        end_test("reset");

        $display("%0d tests passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* hdl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::addr_t        fetch_pc,
    output fetch_pkg::bpu_read_t    bpu_rd,
    input  fetch_pkg::bpu_fill_t    bpu_fill,
    input  logic                    fill_en,
    input  fetch_pkg::bpu_resolve_t resolve
);
    import fetch_pkg::*;

    logic [btb_entries-1:0] valid;
    btb_tag_t               tag    [btb_entries];
    addr_t                  target [btb_entries];
    bpu_cnt_t               cnt    [btb_entries];

    addr_t      rd_pc [fetch_width];
    slot_mask_t fill_we;
    slot_mask_t fill_hit;
    btb_idx_t   res_idx;
    logic       res_hit;

    function automatic btb_idx_t idx_of(addr_t pc);
        return pc[btb_idx_w+1:2];
    endfunction

    function automatic btb_tag_t tag_of(addr_t pc);
        return pc[31:btb_idx_w+2];
    endfunction

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            rd_pc[i]          = fetch_pc + addr_t'(4 * i);
            bpu_rd.hit[i]     = valid[idx_of(rd_pc[i])] &&
                                tag[idx_of(rd_pc[i])] == tag_of(rd_pc[i]);
            bpu_rd.predict[i] = cnt[idx_of(rd_pc[i])][1];
            bpu_rd.target[i]  = target[idx_of(rd_pc[i])];

            fill_we[i]  = fill_en & bpu_fill.is_branch[i];
            fill_hit[i] = valid[idx_of(bpu_fill.pc[i])] &&
                          tag[idx_of(bpu_fill.pc[i])] == tag_of(bpu_fill.pc[i]);
        end
    end

    assign res_idx = idx_of(resolve.pc);
    assign res_hit = resolve.valid && valid[res_idx] && tag[res_idx] == tag_of(resolve.pc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < fetch_width; i++) begin
                if (fill_we[i]) begin
                    valid[idx_of(bpu_fill.pc[i])] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (fill_we[i]) begin
                tag[idx_of(bpu_fill.pc[i])] <= tag_of(bpu_fill.pc[i]);
                if (!bpu_fill.no_target[i]) begin
                    target[idx_of(bpu_fill.pc[i])] <= bpu_fill.target[i];
                end
                // a refill of a live entry keeps its history
                if (!fill_hit[i]) begin
                    cnt[idx_of(bpu_fill.pc[i])] <= bpu_weak_nt;
                end
            end
        end
        // applied last so training overrides a fill on the same entry
        if (res_hit) begin
            if (resolve.taken && cnt[res_idx] != 2'b11) begin
                cnt[res_idx] <= cnt[res_idx] + 2'd1;
            end else if (!resolve.taken && cnt[res_idx] != 2'b00) begin
                cnt[res_idx] <= cnt[res_idx] - 2'd1;
            end
        end
    end

endmodule

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 miss,
    input  logic                 refill_done,
    input  fetch_pkg::fifo_cnt_t fifo_count,
    output logic                 hint,
    output logic                 refill_req
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            fetch_run: begin
                if (miss) begin
                    state_next = fetch_refill;
                end
            end
            fetch_refill: begin
                if (refill_done) begin
                    state_next = fetch_run;
                end
            end
            default: begin
                state_next = fetch_run;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= fetch_run;
            refill_req <= 1'b0;
        end else begin
            state      <= state_next;
            // one pulse on entry to refill
            refill_req <= (state == fetch_run) && (state_next == fetch_refill);
        end
    end

    // need room for a whole group before fetching
    assign hint = (state == fetch_run) &&
                  (fifo_count <= fifo_cnt_t'(fifo_depth - fetch_width));

endmodule

/* hdl/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::icache_rsp_t  icache_rsp,
    output fetch_pkg::addr_t        fetch_pc,
    output logic                    refill_req,
    output fetch_pkg::addr_t        refill_pc,
    input  logic                    refill_done,
    input  fetch_pkg::bpu_resolve_t resolve,
    input  logic                    pop,
    output fetch_pkg::fetch_entry_t head,
    output logic                    head_valid
);
    import fetch_pkg::*;

    logic                           hint;
    logic                           jump;
    logic                           miss;
    slot_mask_t                     slot_valid;
    addr_t                          jump_target;
    addr_t                          taken_target;
    addr_t                          miss_pc;
    bpu_read_t                      bpu_rd;
    bpu_fill_t                      bpu_fill;
    fifo_cnt_t                      fifo_count;
    fetch_entry_t [fetch_width-1:0] push_data;

    // queue entries pair each slot pc with its word
    for (genvar i = 0; i < fetch_width; i++) begin : g_push
        assign push_data[i] = '{pc: bpu_fill.pc[i], inst: icache_rsp.inst[i]};
    end

    fetch_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .miss        (miss),
        .refill_done (refill_done),
        .fifo_count  (fifo_count),
        .hint        (hint),
        .refill_req  (refill_req)
    );

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .hint         (hint),
        .slot_valid   (slot_valid),
        .jump         (jump),
        .jump_target  (jump_target),
        .taken_target (taken_target),
        .miss         (miss),
        .miss_pc      (miss_pc),
        .fetch_pc     (fetch_pc),
        .refill_pc    (refill_pc)
    );

    predecoder u_predecoder (
        .fetch_pc     (fetch_pc),
        .icache_rsp   (icache_rsp),
        .hint         (hint),
        .bpu_rd       (bpu_rd),
        .slot_valid   (slot_valid),
        .jump         (jump),
        .jump_target  (jump_target),
        .taken_target (taken_target),
        .miss         (miss),
        .miss_pc      (miss_pc),
        .bpu_fill     (bpu_fill)
    );

    branch_predictor u_bpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_pc (fetch_pc),
        .bpu_rd   (bpu_rd),
        .bpu_fill (bpu_fill),
        .fill_en  (hint),
        .resolve  (resolve)
    );

    inst_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_mask  (slot_valid),
        .push_data  (push_data),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .count      (fifo_count)
    );

endmodule

/* hdl/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hint,
    input  fetch_pkg::slot_mask_t slot_valid,
    input  logic                  jump,
    input  fetch_pkg::addr_t      jump_target,
    input  fetch_pkg::addr_t      taken_target,
    input  logic                  miss,
    input  fetch_pkg::addr_t      miss_pc,
    output fetch_pkg::addr_t      fetch_pc,
    output fetch_pkg::addr_t      refill_pc
);
    import fetch_pkg::*;

    addr_t pc_next;

    // miss beats jump beats predicted branch / fall-through
    always_comb begin
        pc_next = fetch_pc;
        if (hint) begin
            if (miss) begin
                pc_next = miss_pc;
            end else if (jump) begin
                pc_next = jump_target;
            end else if (|slot_valid) begin
                pc_next = taken_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= '0;
        end else begin
            fetch_pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hint && miss) begin
            refill_pc <= miss_pc;
        end
    end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // fetch group geometry
    localparam int fetch_width = 4;

    // branch target buffer, direct mapped on word address bits
    localparam int btb_entries = 16;
    localparam int btb_idx_w   = $clog2(btb_entries);

    // instruction queue
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    typedef logic [31:0]              addr_t;
    typedef logic [31:0]              inst_t;
    typedef logic [fetch_width-1:0]   slot_mask_t;
    typedef logic [btb_idx_w-1:0]     btb_idx_t;
    typedef logic [31:btb_idx_w+2]    btb_tag_t;
    typedef logic [1:0]               bpu_cnt_t;
    typedef logic [fifo_ptr_w-1:0]    fifo_ptr_t;
    typedef logic [fifo_ptr_w:0]      fifo_cnt_t;

    // counter value for a freshly filled entry
    localparam bpu_cnt_t bpu_weak_nt = 2'b01;

    typedef struct packed {
        inst_t [fetch_width-1:0] inst;
        slot_mask_t              found;
    } icache_rsp_t;

    typedef struct packed {
        slot_mask_t              hit;
        slot_mask_t              predict;
        addr_t [fetch_width-1:0] target;
    } bpu_read_t;

    typedef struct packed {
        slot_mask_t              is_branch;
        slot_mask_t              no_target;
        addr_t [fetch_width-1:0] target;
        addr_t [fetch_width-1:0] pc;
    } bpu_fill_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
    } bpu_resolve_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_entry_t;

    typedef enum logic {
        fetch_run,
        fetch_refill
    } fetch_state_t;

endpackage

/* hdl/inst_fifo.sv */
`timescale 1ns/1ps

module inst_fifo (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  fetch_pkg::slot_mask_t                          push_mask,
    input  fetch_pkg::fetch_entry_t [fetch_pkg::fetch_width-1:0] push_data,
    input  logic                                           pop,
    output fetch_pkg::fetch_entry_t                        head,
    output logic                                           head_valid,
    output fetch_pkg::fifo_cnt_t                           count
);
    import fetch_pkg::*;

    fetch_entry_t mem [fifo_depth];
    fifo_ptr_t    wr_ptr;
    fifo_ptr_t    rd_ptr;
    fifo_ptr_t    slot_addr [fetch_width];
    fifo_cnt_t    push_cnt;
    logic         pop_ok;

    // compact the pushed slots behind the write pointer
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < fetch_width; i++) begin
            slot_addr[i] = wr_ptr + fifo_ptr_t'(push_cnt);
            push_cnt     = push_cnt + fifo_cnt_t'(push_mask[i]);
        end
    end

    assign pop_ok = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(push_cnt);
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push_cnt - fifo_cnt_t'(pop_ok);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (push_mask[i]) begin
                mem[slot_addr[i]] <= push_data[i];
            end
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

endmodule

/* hdl/predecoder.sv */
`timescale 1ns/1ps
`include "la_opcodes.svh"

module predecoder (
    input  fetch_pkg::addr_t       fetch_pc,
    input  fetch_pkg::icache_rsp_t icache_rsp,
    input  logic                   hint,
    input  fetch_pkg::bpu_read_t   bpu_rd,
    output fetch_pkg::slot_mask_t  slot_valid,
    output logic                   jump,
    output fetch_pkg::addr_t       jump_target,
    output fetch_pkg::addr_t       taken_target,
    output logic                   miss,
    output fetch_pkg::addr_t       miss_pc,
    output fetch_pkg::bpu_fill_t   bpu_fill
);
    import fetch_pkg::*;

    addr_t      slot_pc [fetch_width];
    addr_t      jmp_tgt [fetch_width];
    addr_t      br_tgt  [fetch_width];
    slot_mask_t is_jump;
    slot_mask_t is_branch;
    slot_mask_t is_jirl;
    slot_mask_t token;

    // per slot class and targets
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            slot_pc[i] = fetch_pc + addr_t'(4 * i);
            casez (icache_rsp.inst[i])
                `B, `BL:
                    {is_jump[i], is_branch[i], is_jirl[i]} = 3'b100;
                `BEQ, `BNE, `BLT, `BGE, `BLTU, `BGEU:
                    {is_jump[i], is_branch[i], is_jirl[i]} = 3'b010;
                `JIRL:
                    {is_jump[i], is_branch[i], is_jirl[i]} = 3'b011;
                default:
                    {is_jump[i], is_branch[i], is_jirl[i]} = 3'b000;
            endcase
            // jump offset: high part is in bits 9:0
            jmp_tgt[i] = slot_pc[i] + {{4{icache_rsp.inst[i][9]}}, icache_rsp.inst[i][9:0],
                                       icache_rsp.inst[i][25:10], 2'b00};
            br_tgt[i]  = slot_pc[i] + {{14{icache_rsp.inst[i][25]}},
                                       icache_rsp.inst[i][25:10], 2'b00};
            token[i]   = is_jump[i] | (bpu_rd.hit[i] & bpu_rd.predict[i]);
        end
    end

    // group runs up to the first token, stops early at the first missing slot
    always_comb begin
        logic live;
        live       = hint;
        slot_valid = '0;
        miss       = 1'b0;
        miss_pc    = '0;
        for (int i = 0; i < fetch_width; i++) begin
            if (live && !icache_rsp.found[i]) begin
                miss    = 1'b1;
                miss_pc = slot_pc[i];
            end
            slot_valid[i] = live & icache_rsp.found[i];
            live          = live & icache_rsp.found[i] & ~token[i];
        end
    end

    // only the last valid slot can carry a token
    always_comb begin
        jump         = 1'b0;
        jump_target  = '0;
        // falls through to the next group when nothing redirects
        taken_target = fetch_pc + addr_t'(4 * fetch_width);
        for (int i = 0; i < fetch_width; i++) begin
            if (slot_valid[i] && is_jump[i]) begin
                jump        = 1'b1;
                jump_target = jmp_tgt[i];
            end else if (slot_valid[i] && token[i]) begin
                taken_target = bpu_rd.target[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            bpu_fill.is_branch[i] = slot_valid[i] & is_branch[i];
            // jirl target is not known here, keep what the buffer has
            bpu_fill.no_target[i] = is_jirl[i];
            bpu_fill.target[i]    = br_tgt[i];
            bpu_fill.pc[i]        = slot_pc[i];
        end
    end

endmodule

/* include/la_opcodes.svh */
`ifndef LA_OPCODES_SVH
`define LA_OPCODES_SVH

// major opcode sits in bits 31:26

// unconditional jumps, 26-bit offset
`define B    32'b010100_??????????_??????????_??????
`define BL   32'b010101_??????????_??????????_??????

// conditional branches, 16-bit offset in bits 25:10
`define BEQ  32'b010110_??????????_??????????_??????
`define BNE  32'b010111_??????????_??????????_??????
`define BLT  32'b011000_??????????_??????????_??????
`define BGE  32'b011001_??????????_??????????_??????
`define BLTU 32'b011010_??????????_??????????_??????
`define BGEU 32'b011011_??????????_??????????_??????

// register indirect
`define JIRL 32'b010011_??????????_??????????_??????

`endif

/* list.f */
+incdir+include
hdl/fetch_pkg.sv
hdl/predecoder.sv
hdl/branch_predictor.sv
hdl/fetch_ctrl.sv
hdl/fetch_pc_gen.sv
hdl/inst_fifo.sv
hdl/fetch_frontend.sv
dv/fetch_frontend_assertions.sv
dv/fetch_frontend_tb.sv
